// ==== include/conv_params.svh ====
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// Layer shape
`define CONV_IC     4
`define CONV_OC     3
`define CONV_H      6
`define CONV_W      6
`define CONV_OH     4
`define CONV_OW     4

// Datapath
`define CONV_SHIFT  4       // Right shift before saturation
`define CONV_ACC_W  20
`define CONV_ADDR_W 6

`endif

// ==== hdl/conv_pkg.sv ====
`default_nettype none
`include "conv_params.svh"

package conv_pkg;

    typedef logic signed [7:0]              pixel_t;
    typedef logic signed [7:0]              weight_t;
    typedef logic [9*8-1:0]                 kernel_t;   // Tap 0 in the low byte
    typedef logic signed [`CONV_ACC_W-1:0]  acc_t;
    typedef logic [`CONV_ADDR_W-1:0]        addr_t;     // Row * W + col
    typedef logic [1:0]                     chan_t;
    typedef logic [2:0]                     coord_t;
    typedef logic [3:0]                     tap_t;

    typedef enum logic [2:0] {
        IDLE, LOAD, SCAN, DRAIN, FINISH
    } ctrl_state_t;

    typedef enum logic [1:0] {
        S_IDLE, S_READ, S_WAIT, S_HOLD
    } scan_state_t;

endpackage

`default_nettype wire

// ==== hdl/partial_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_params.svh"

interface partial_if;
    import conv_pkg::*;

    logic   valid;
    logic   ready;
    acc_t   sums [`CONV_IC];    // One partial per input channel
    coord_t row;
    coord_t col;
    chan_t  channel;

    modport scan (output valid, output row, output col, input ready);
    modport engine (output sums);
    modport sink (input valid, input sums, input row, input col, input channel,
                  output ready);

endinterface

`default_nettype wire

// ==== hdl/layer_control.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_params.svh"

module layer_control (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  logic            scan_done,
    input  logic            out_empty,
    output logic            c_load,
    output logic            scan_start,
    output conv_pkg::chan_t channel,
    output logic            busy,
    output logic            done
);
    import conv_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        last_channel;

    assign last_channel = (channel == chan_t'(`CONV_OC - 1));

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = LOAD;
                end
            end
            LOAD:   state_next = SCAN;
            SCAN: begin
                if (scan_done) begin
                    state_next = last_channel ? DRAIN : LOAD;
                end
            end
            DRAIN: begin
                if (out_empty) begin    // Last pixel has left the output register
                    state_next = FINISH;
                end
            end
            FINISH: state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            channel <= '0;
        end else begin
            state <= state_next;
            if (state == IDLE && start) begin
                channel <= '0;
            end else if (state == SCAN && scan_done && !last_channel) begin
                channel <= channel + 1'b1;
            end
        end
    end

    assign c_load     = (state == LOAD);
    assign scan_start = (state == LOAD);    // Scanner's first address lands after the load
    assign busy       = (state != IDLE);
    assign done       = (state == FINISH);

endmodule

`default_nettype wire

// ==== hdl/window_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_params.svh"

module window_scanner (
    input  logic            clk,
    input  logic            rst,
    input  logic            scan_start,
    output conv_pkg::addr_t rd_addr,
    output logic            tap_valid,
    output logic            tap_first,
    output conv_pkg::tap_t  tap,
    output logic            scan_done,
    partial_if.scan         part
);
    import conv_pkg::*;

    scan_state_t state;
    coord_t      row;
    coord_t      col;
    tap_t        tap_cnt;
    logic [1:0]  kr;            // Tap row within the window
    logic [1:0]  kc;            // Tap column within the window
    logic        last_tap;
    logic        last_window;
    logic        accept;

    assign last_tap    = (tap_cnt == tap_t'(8));
    assign last_window = (row == coord_t'(`CONV_OH - 1)) && (col == coord_t'(`CONV_OW - 1));
    assign accept      = part.valid && part.ready;
    assign scan_done   = (state == S_HOLD) && accept && last_window;

    assign part.row = row;
    assign part.col = col;

    assign rd_addr = (addr_t'(row) + addr_t'(kr)) * addr_t'(`CONV_W)
                   + addr_t'(col) + addr_t'(kc);

    // ####################
    // Window walk

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            part.valid <= 1'b0;
            tap_valid  <= 1'b0;
            tap_first  <= 1'b0;
            tap        <= '0;
            row        <= '0;
            col        <= '0;
            tap_cnt    <= '0;
            kr         <= '0;
            kc         <= '0;
        end else begin
            // Lined up with the read data one cycle later
            tap_valid <= (state == S_READ);
            tap_first <= (state == S_READ) && (tap_cnt == '0);
            tap       <= tap_cnt;

            case (state)
                S_IDLE: begin
                    if (scan_start) begin
                        row     <= '0;
                        col     <= '0;
                        tap_cnt <= '0;
                        kr      <= '0;
                        kc      <= '0;
                        state   <= S_READ;
                    end
                end
                S_READ: begin
                    tap_cnt <= tap_cnt + 1'b1;
                    if (kc == 2'd2) begin
                        kc <= '0;
                        kr <= kr + 1'b1;
                    end else begin
                        kc <= kc + 1'b1;
                    end
                    if (last_tap) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin           // Tap 8 accumulates here
                    part.valid <= 1'b1;
                    state      <= S_HOLD;
                end
                S_HOLD: begin
                    if (accept) begin
                        part.valid <= 1'b0;
                        tap_cnt    <= '0;
                        kr         <= '0;
                        kc         <= '0;
                        if (last_window) begin
                            state <= S_IDLE;
                        end else begin
                            state <= S_READ;
                            if (col == coord_t'(`CONV_OW - 1)) begin
                                col <= '0;
                                row <= row + 1'b1;
                            end else begin
                                col <= col + 1'b1;
                            end
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/conv_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_engine (
    input  logic              clk,
    input  logic              rst,
    input  conv_pkg::pixel_t  pixel,
    input  conv_pkg::kernel_t kernel,
    input  logic              tap_valid,
    input  logic              tap_first,
    input  conv_pkg::tap_t    tap,
    output conv_pkg::acc_t    sum
);
    import conv_pkg::*;

    weight_t weight;
    acc_t    product;

    assign weight  = weight_t'(kernel[8*tap +: 8]);
    assign product = acc_t'(pixel) * acc_t'(weight);    // Both sides sign extended

    always_ff @(posedge clk) begin
        if (rst) begin
            sum <= '0;
        end else if (tap_valid) begin
            if (tap_first) begin
                sum <= product;     // New window
            end else begin
                sum <= sum + product;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/weight_rom.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_params.svh"

module weight_rom (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                c_load,
    input  conv_pkg::chan_t                     channel,
    output conv_pkg::kernel_t [`CONV_IC-1:0]    kernels,
    output conv_pkg::acc_t                      bias
);
    import conv_pkg::*;

    // Fixed table, weights fall in -4 .. 4
    function automatic weight_t tap_weight(input int o, input int i, input int k);
        int m;
        m = (7 * o + 5 * i + 3 * k) % 9;
        return weight_t'(m - 4);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            kernels <= '0;
            bias    <= '0;
        end else if (c_load) begin
            for (int i = 0; i < `CONV_IC; i++) begin
                for (int k = 0; k < 9; k++) begin
                    kernels[i][8*k +: 8] <= tap_weight(int'(channel), i, k);
                end
            end
            bias <= acc_t'(16 * (int'(channel) - 1));
        end
    end

endmodule

`default_nettype wire

// ==== hdl/channel_adder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_params.svh"

module channel_adder (
    input  logic             clk,
    input  logic             rst,
    partial_if.sink          part,
    input  conv_pkg::acc_t   bias,
    output logic             out_valid,
    input  logic             out_ready,
    output conv_pkg::pixel_t out_data,
    output conv_pkg::chan_t  out_channel,
    output conv_pkg::coord_t out_row,
    output conv_pkg::coord_t out_col,
    output logic             out_empty
);
    import conv_pkg::*;

    localparam int PAIRS = `CONV_IC / 2;

    acc_t   pair_sum [PAIRS];
    acc_t   total;
    acc_t   shifted;
    pixel_t saturated;
    logic   accept;

    // ####################
    // Adder tree

    for (genvar p = 0; p < PAIRS; p++) begin : g_pair
        assign pair_sum[p] = part.sums[2*p] + part.sums[2*p+1];
    end

    always_comb begin
        total = bias;
        for (int p = 0; p < PAIRS; p++) begin
            total = total + pair_sum[p];
        end
    end

    assign shifted = total >>> `CONV_SHIFT;     // Floor toward minus infinity

    always_comb begin
        if (shifted > acc_t'(127)) begin
            saturated = pixel_t'(127);
        end else if (shifted < acc_t'(-128)) begin
            saturated = pixel_t'(-128);
        end else begin
            saturated = pixel_t'(shifted);
        end
    end

    // ####################
    // Output register

    assign part.ready = !out_valid || out_ready;
    assign accept     = part.valid && part.ready;
    assign out_empty  = !out_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_data    <= saturated;
            out_channel <= part.channel;
            out_row     <= part.row;
            out_col     <= part.col;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/conv_layer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_params.svh"

module conv_layer (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,
    output logic                                busy,
    output logic                                done,
    output conv_pkg::addr_t                     rd_addr,
    input  conv_pkg::pixel_t [`CONV_IC-1:0]     rd_data,
    output logic                                out_valid,
    input  logic                                out_ready,
    output conv_pkg::pixel_t                    out_data,
    output conv_pkg::chan_t                     out_channel,
    output conv_pkg::coord_t                    out_row,
    output conv_pkg::coord_t                    out_col
);
    import conv_pkg::*;

    logic                       c_load;
    logic                       scan_start;
    logic                       scan_done;
    logic                       out_empty;
    logic                       tap_valid;
    logic                       tap_first;
    tap_t                       tap;
    kernel_t [`CONV_IC-1:0]     kernels;
    acc_t                       bias;

    partial_if part ();

    layer_control u_control (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .scan_done  (scan_done),
        .out_empty  (out_empty),
        .c_load     (c_load),
        .scan_start (scan_start),
        .channel    (part.channel),
        .busy       (busy),
        .done       (done)
    );

    window_scanner u_scanner (
        .clk        (clk),
        .rst        (rst),
        .scan_start (scan_start),
        .rd_addr    (rd_addr),
        .tap_valid  (tap_valid),
        .tap_first  (tap_first),
        .tap        (tap),
        .scan_done  (scan_done),
        .part       (part.scan)
    );

    weight_rom u_weights (
        .clk     (clk),
        .rst     (rst),
        .c_load  (c_load),
        .channel (part.channel),
        .kernels (kernels),
        .bias    (bias)
    );

    // One engine per input channel
    for (genvar g = 0; g < `CONV_IC; g++) begin : g_engine
        conv_engine u_engine (
            .clk       (clk),
            .rst       (rst),
            .pixel     (rd_data[g]),
            .kernel    (kernels[g]),
            .tap_valid (tap_valid),
            .tap_first (tap_first),
            .tap       (tap),
            .sum       (part.sums[g])
        );
    end

    channel_adder u_adder (
        .clk         (clk),
        .rst         (rst),
        .part        (part.sink),
        .bias        (bias),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .out_channel (out_channel),
        .out_row     (out_row),
        .out_col     (out_col),
        .out_empty   (out_empty)
    );

endmodule

`default_nettype wire

// ==== tb/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb/conv_layer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_params.svh"

module conv_layer_tb;
    import conv_pkg::*;

    localparam int OUTPUTS        = `CONV_OC * `CONV_OH * `CONV_OW;
    localparam int PIXELS         = `CONV_H * `CONV_W;
    localparam int TIMEOUT_CYCLES = 20000;  // Five runs of 48 outputs at ~12 cycles, doubled, plus headroom

    logic                       clk;
    logic                       rst;
    logic                       start;
    logic                       busy;
    logic                       done;
    addr_t                      rd_addr;
    pixel_t [`CONV_IC-1:0]      rd_data;
    logic                       out_valid;
    logic                       out_ready;
    pixel_t                     out_data;
    chan_t                      out_channel;
    coord_t                     out_row;
    coord_t                     out_col;

    integer     seed;
    int         cycle_count;
    int         done_count;
    pixel_t     fmap [`CONV_IC][PIXELS];
    pixel_t     got_data [$];
    chan_t      got_channel [$];
    coord_t     got_row [$];
    coord_t     got_col [$];
    logic       hold_pending;
    pixel_t     hold_data;
    chan_t      hold_channel;
    coord_t     hold_row;
    coord_t     hold_col;

    clock_gen clocks (
        .clk (clk),
        .rst (rst)
    );

    conv_layer dut (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .busy        (busy),
        .done        (done),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .out_channel (out_channel),
        .out_row     (out_row),
        .out_col     (out_col)
    );

    // ####################
    // Feature map, monitor and timeout

    always @(posedge clk) begin
        for (int i = 0; i < `CONV_IC; i++) begin
            rd_data[i] <= fmap[i][rd_addr];     // One cycle read latency
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (hold_pending) begin             // Previous cycle was stalled
                check_value("out_valid while stalled", out_valid, 1);
                check_value("out_data while stalled", out_data, hold_data);
                check_value("out_channel while stalled", out_channel, hold_channel);
                check_value("out_row while stalled", out_row, hold_row);
                check_value("out_col while stalled", out_col, hold_col);
            end
            hold_pending = out_valid && !out_ready;
            hold_data    = out_data;
            hold_channel = out_channel;
            hold_row     = out_row;
            hold_col     = out_col;
            if (out_valid && out_ready) begin
                got_data.push_back(out_data);
                got_channel.push_back(out_channel);
                got_row.push_back(out_row);
                got_col.push_back(out_col);
            end
            if (done) begin
                done_count++;
                check_value("outputs accepted before done", got_data.size(), OUTPUTS);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $fatal(1, "Timeout");
        end
    end

    // ####################
    // Reference model and helpers

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch");
        end
    endtask

    function automatic int kernel_weight(input int o, input int i, input int k);
        return ((7 * o + 5 * i + 3 * k) % 9) - 4;
    endfunction

    function automatic pixel_t expected_pixel(input int o, input int r, input int c);
        int total;
        int shifted;
        total = 16 * (o - 1);
        for (int i = 0; i < `CONV_IC; i++) begin
            for (int k = 0; k < 9; k++) begin
                total += int'(fmap[i][(r + k / 3) * `CONV_W + c + k % 3]) * kernel_weight(o, i, k);
            end
        end
        shifted = total >>> `CONV_SHIFT;    // Floor division
        if (shifted > 127) begin
            return pixel_t'(127);
        end else if (shifted < -128) begin
            return pixel_t'(-128);
        end
        return pixel_t'(shifted);
    endfunction

    task automatic fill_random_image();
        for (int i = 0; i < `CONV_IC; i++) begin
            for (int a = 0; a < PIXELS; a++) begin
                fmap[i][a] = pixel_t'($random(seed));
            end
        end
    endtask

    task automatic fill_constant_image(input pixel_t value);
        for (int i = 0; i < `CONV_IC; i++) begin
            for (int a = 0; a < PIXELS; a++) begin
                fmap[i][a] = value;
            end
        end
    endtask

    // Channels 0 and 3 at one extreme, 1 and 2 at the other
    task automatic fill_extreme_image(input bit invert);
        pixel_t value;
        for (int i = 0; i < `CONV_IC; i++) begin
            value = ((i % 3 == 0) != invert) ? pixel_t'(-128) : pixel_t'(127);
            for (int a = 0; a < PIXELS; a++) begin
                fmap[i][a] = value;
            end
        end
    endtask

    task automatic run_layer(input bit random_ready, input bit extra_start);
        int cycles;
        cycles = 0;
        got_data.delete();
        got_channel.delete();
        got_row.delete();
        got_col.delete();
        done_count = 0;
        @(posedge clk);
        start     <= 1'b1;
        out_ready <= 1'b1;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > 1) begin
                check_value("busy during run", busy, 1);
            end
            start <= extra_start && (cycles == 40);     // Lands in the middle of a scan
            if (random_ready) begin
                out_ready <= ($random(seed) % 2 == 0);
            end
        end while (!done);
        start     <= 1'b0;
        out_ready <= 1'b1;
        @(posedge clk);
        check_value("busy after done", busy, 0);
        repeat (3) @(posedge clk);
        check_value("done pulse count", done_count, 1);
    endtask

    task automatic compare_outputs();
        int o;
        int r;
        int c;
        check_value("output count", got_data.size(), OUTPUTS);
        for (int idx = 0; idx < OUTPUTS; idx++) begin
            o = idx / (`CONV_OH * `CONV_OW);
            r = (idx % (`CONV_OH * `CONV_OW)) / `CONV_OW;
            c = idx % `CONV_OW;
            check_value($sformatf("out_channel[%0d]", idx), got_channel[idx], o);
            check_value($sformatf("out_row[%0d]", idx), got_row[idx], r);
            check_value($sformatf("out_col[%0d]", idx), got_col[idx], c);
            check_value($sformatf("out_data[ch%0d r%0d c%0d]", o, r, c), got_data[idx],
                        expected_pixel(o, r, c));
        end
    endtask

    // ####################
    // Directed tests

    task automatic idle_after_reset();
        @(posedge clk);
        while (rst) @(posedge clk);
        repeat (5) begin
            @(posedge clk);
            check_value("out_valid after reset", out_valid, 0);
            check_value("done after reset", done, 0);
            check_value("busy after reset", busy, 0);
        end
    endtask

    task automatic full_run_ready_high();
        fill_random_image();
        run_layer(1'b0, 1'b0);
        compare_outputs();
    endtask

    task automatic run_with_backpressure();
        run_layer(1'b1, 1'b0);  // Same image as the previous run
        compare_outputs();
    endtask

    task automatic saturate_extremes();
        fill_extreme_image(1'b0);
        run_layer(1'b0, 1'b0);
        compare_outputs();
        fill_extreme_image(1'b1);
        run_layer(1'b0, 1'b0);
        compare_outputs();
    endtask

    task automatic ignore_start_while_busy();
        fill_random_image();
        run_layer(1'b0, 1'b1);
        compare_outputs();
    endtask

    initial begin
        seed         = 32'h4ca1_7899;
        cycle_count  <= 0;
        done_count   = 0;
        hold_pending = 1'b0;
        start        <= 1'b0;
        out_ready    <= 1'b0;
        rd_data      <= '0;
        fill_constant_image(pixel_t'(0));

        idle_after_reset();
        $display("Reset state ok");
        full_run_ready_high();
        $display("Full run with out_ready high ok");
        run_with_backpressure();
        $display("Run with back-pressure ok");
        saturate_extremes();
        $display("Saturation runs ok");
        ignore_start_while_busy();
        $display("Start while busy ignored, second image ok");

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
hdl/conv_pkg.sv
hdl/partial_if.sv
hdl/layer_control.sv
hdl/window_scanner.sv
hdl/conv_engine.sv
hdl/weight_rom.sv
hdl/channel_adder.sv
hdl/conv_layer.sv
tb/clock_gen.sv
tb/conv_layer_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the conv layer testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f tb.f --top-module conv_layer_tb -Mdir obj_dir -o sim_conv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_conv)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
